//--- mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// ---------------------------------------------------------------------
// Architecture widths
// ---------------------------------------------------------------------
`define MIPS_DATA_W      32                 // Data word width
`define MIPS_REG_ADDR_W  5                  // Register index width
`define MIPS_REG_NUM     32                 // GPR count
`define MIPS_RESET_PC    32'h0000_0000      // First fetch address
`define MIPS_PC_STEP     32'd4              // Byte step per instruction

// ---------------------------------------------------------------------
// Primary opcodes, inst[31:26]
// ---------------------------------------------------------------------
`define MIPS_OP_SPECIAL  6'b000000          // R-type, decoded by funct
`define MIPS_OP_ANDI     6'b001100
`define MIPS_OP_ORI      6'b001101
`define MIPS_OP_XORI     6'b001110
`define MIPS_OP_LUI      6'b001111
`define MIPS_OP_ADDIU    6'b001001

// SPECIAL function codes, inst[5:0]
`define MIPS_FN_AND      6'b100100
`define MIPS_FN_OR       6'b100101
`define MIPS_FN_XOR      6'b100110
`define MIPS_FN_NOR      6'b100111
`define MIPS_FN_ADDU     6'b100001
`define MIPS_FN_SUBU     6'b100011
`define MIPS_FN_SLT      6'b101010
`define MIPS_FN_SLL      6'b000000          // All-zero word is SLL r0 = NOP
`define MIPS_FN_SRL      6'b000010
`define MIPS_FN_SRA      6'b000011

`endif

//--- mips_pkg.sv
`include "mips_defines.svh"

package mips_pkg;

    // ---------------------------------------------------------------------
    // Basic vector types
    // ---------------------------------------------------------------------
    typedef logic [`MIPS_DATA_W-1:0]     word_t;       // GPR / ALU word
    typedef logic [`MIPS_DATA_W-1:0]     inst_addr_t;  // Byte address into ROM
    typedef logic [`MIPS_DATA_W-1:0]     inst_t;       // Raw instruction
    typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;   // GPR index

    // ALU operation selected by decode
    typedef enum logic [3:0] {
        ALU_NOP = 4'd0,                                // Result forced to zero
        ALU_OR  = 4'd1,
        ALU_AND = 4'd2,
        ALU_XOR = 4'd3,
        ALU_NOR = 4'd4,
        ALU_ADD = 4'd5,                                // Wraps, no overflow trap
        ALU_SUB = 4'd6,
        ALU_SLT = 4'd7,                                // Signed compare
        ALU_SLL = 4'd8,
        ALU_SRL = 4'd9,
        ALU_SRA = 4'd10,
        ALU_LUI = 4'd11                                // Immediate to upper half
    } alu_op_e;

    // ---------------------------------------------------------------------
    // Pipeline buses
    // ---------------------------------------------------------------------
    typedef struct packed {
        logic       valid;                             // Slot holds a fetched word
        inst_addr_t pc;
        inst_t      inst;
    } fetch_bus_t;                                     // IF/ID, 65 bits

    typedef struct packed {
        alu_op_e    alu_op;
        word_t      opa;                               // rs value or shamt
        word_t      opb;                               // rt value or immediate
        reg_addr_t  wd;                                // Destination index
        logic       wreg;                              // Destination write enable
    } issue_bus_t;                                     // ID/EX, 74 bits

    typedef struct packed {
        logic       wreg;
        reg_addr_t  wd;
        word_t      wdata;
    } wb_bus_t;                                        // Result tap, 38 bits

endpackage

//--- fetch_stage.sv
`include "mips_defines.svh"

module fetch_stage (
    input  logic                 clk,
    input  logic                 reset_i,
    output logic                 rom_ce_o,
    output mips_pkg::inst_addr_t rom_addr_o,
    input  mips_pkg::inst_t      rom_data_i,
    output mips_pkg::fetch_bus_t fetch_o
);
    import mips_pkg::*;

    logic       ce_q;                                  // Fetch enable
    inst_addr_t pc_q;                                  // Program counter
    logic       id_valid_q;                            // IF/ID control
    inst_addr_t id_pc_q;                               // IF/ID payload
    inst_t      id_inst_q;

    // ---------------------------------------------------------------------
    // PC register
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ce_q <= 1'b0;
        end else begin
            ce_q <= 1'b1;                              // Enabled one edge after reset
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || !ce_q) begin
            pc_q <= `MIPS_RESET_PC;                    // Hold start address until enabled
        end else begin
            pc_q <= pc_q + `MIPS_PC_STEP;              // No stalls, step every cycle
        end
    end

    assign rom_ce_o   = ce_q;
    assign rom_addr_o = pc_q;

    // ---------------------------------------------------------------------
    // IF/ID register
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            id_valid_q <= 1'b0;
        end else begin
            id_valid_q <= ce_q;                        // Disabled fetch gives a bubble
        end
    end

    always_ff @(posedge clk) begin
        id_pc_q   <= pc_q;
        id_inst_q <= rom_data_i;                       // ROM read is combinational
    end

    assign fetch_o = '{valid: id_valid_q, pc: id_pc_q, inst: id_inst_q};

endmodule

//--- regfile.sv
`include "mips_defines.svh"

module regfile (
    input  logic                clk,
    input  logic                reset_i,
    input  mips_pkg::reg_addr_t raddr1_i,
    input  mips_pkg::reg_addr_t raddr2_i,
    output mips_pkg::word_t     rdata1_o,
    output mips_pkg::word_t     rdata2_o,
    input  mips_pkg::wb_bus_t   wb_i
);
    import mips_pkg::*;

    word_t regs [`MIPS_REG_NUM];                       // GPR storage

    // One read port with write-through from the WB bus
    function automatic word_t read_port(reg_addr_t addr, word_t stored, wb_bus_t wb);
        word_t res;
        if (addr == '0) begin
            res = '0;                                  // r0 is hardwired
        end else if (wb.wreg && (wb.wd == addr)) begin
            res = wb.wdata;                            // Same-cycle write bypass
        end else begin
            res = stored;
        end
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `MIPS_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.wreg && (wb_i.wd != '0)) begin
            regs[wb_i.wd] <= wb_i.wdata;               // r0 never written
        end
    end

    assign rdata1_o = read_port(raddr1_i, regs[raddr1_i], wb_i);
    assign rdata2_o = read_port(raddr2_i, regs[raddr2_i], wb_i);

endmodule

//--- decode_stage.sv
`include "mips_defines.svh"

module decode_stage (
    input  logic                 clk,
    input  logic                 reset_i,
    input  mips_pkg::fetch_bus_t fetch_i,
    output mips_pkg::reg_addr_t  raddr1_o,
    output mips_pkg::reg_addr_t  raddr2_o,
    input  mips_pkg::word_t      rdata1_i,
    input  mips_pkg::word_t      rdata2_i,
    input  mips_pkg::wb_bus_t    ex_fwd_i,
    input  mips_pkg::wb_bus_t    mem_fwd_i,
    output mips_pkg::issue_bus_t issue_o
);
    import mips_pkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [4:0]  shamt;
    logic [15:0] imm;
    word_t       imm_zext;                             // Logic ops, LUI
    word_t       imm_sext;                             // ADDIU
    word_t       shamt_ext;
    word_t       src1;                                 // Forwarded rs value
    word_t       src2;                                 // Forwarded rt value
    alu_op_e     alu_op;
    word_t       opa;
    word_t       opb;
    reg_addr_t   wd;
    logic        known;                                // Opcode/funct recognised
    logic        wreg;
    alu_op_e     alu_op_q;                             // ID/EX control
    logic        wreg_q;
    word_t       opa_q;                                // ID/EX payload
    word_t       opb_q;
    reg_addr_t   wd_q;

    // ---------------------------------------------------------------------
    // Field split
    // ---------------------------------------------------------------------
    assign opcode    = fetch_i.inst[31:26];
    assign rs        = fetch_i.inst[25:21];
    assign rt        = fetch_i.inst[20:16];
    assign rd        = fetch_i.inst[15:11];
    assign shamt     = fetch_i.inst[10:6];
    assign funct     = fetch_i.inst[5:0];
    assign imm       = fetch_i.inst[15:0];
    assign imm_zext  = word_t'(imm);
    assign imm_sext  = {{(`MIPS_DATA_W-16){imm[15]}}, imm};
    assign shamt_ext = word_t'(shamt);

    assign raddr1_o  = rs;                             // Always read both, harmless
    assign raddr2_o  = rt;

    // Youngest producer wins; regfile covers the WB stage itself
    function automatic word_t fwd_sel(reg_addr_t idx, word_t rf_data,
                                      wb_bus_t ex_b, wb_bus_t mem_b);
        word_t res;
        if (idx == '0) begin
            res = '0;
        end else if (ex_b.wreg && (ex_b.wd == idx)) begin
            res = ex_b.wdata;                          // Distance 1
        end else if (mem_b.wreg && (mem_b.wd == idx)) begin
            res = mem_b.wdata;                         // Distance 2
        end else begin
            res = rf_data;                             // Distance 3 via bypass, or older
        end
        return res;
    endfunction

    assign src1 = fwd_sel(rs, rdata1_i, ex_fwd_i, mem_fwd_i);
    assign src2 = fwd_sel(rt, rdata2_i, ex_fwd_i, mem_fwd_i);

    // ---------------------------------------------------------------------
    // Decoder
    // ---------------------------------------------------------------------
    always_comb begin
        alu_op = ALU_NOP;
        opa    = src1;
        opb    = imm_zext;                             // I-type default
        wd     = rt;
        known  = 1'b0;
        case (opcode)
            `MIPS_OP_SPECIAL: begin
                wd    = rd;
                opb   = src2;
                known = 1'b1;
                case (funct)
                    `MIPS_FN_AND:  alu_op = ALU_AND;
                    `MIPS_FN_OR:   alu_op = ALU_OR;
                    `MIPS_FN_XOR:  alu_op = ALU_XOR;
                    `MIPS_FN_NOR:  alu_op = ALU_NOR;
                    `MIPS_FN_ADDU: alu_op = ALU_ADD;
                    `MIPS_FN_SUBU: alu_op = ALU_SUB;
                    `MIPS_FN_SLT:  alu_op = ALU_SLT;
                    `MIPS_FN_SLL: begin
                        alu_op = ALU_SLL;
                        opa    = shamt_ext;            // Shift amount in opa
                    end
                    `MIPS_FN_SRL: begin
                        alu_op = ALU_SRL;
                        opa    = shamt_ext;
                    end
                    `MIPS_FN_SRA: begin
                        alu_op = ALU_SRA;
                        opa    = shamt_ext;
                    end
                    default:       known  = 1'b0;      // Unsupported funct
                endcase
            end
            `MIPS_OP_ORI: begin
                alu_op = ALU_OR;
                known  = 1'b1;
            end
            `MIPS_OP_ANDI: begin
                alu_op = ALU_AND;
                known  = 1'b1;
            end
            `MIPS_OP_XORI: begin
                alu_op = ALU_XOR;
                known  = 1'b1;
            end
            `MIPS_OP_LUI: begin
                alu_op = ALU_LUI;                      // ALU moves imm to upper half
                known  = 1'b1;
            end
            `MIPS_OP_ADDIU: begin
                alu_op = ALU_ADD;
                opb    = imm_sext;
                known  = 1'b1;
            end
            default: ;                                 // Retires as a bubble
        endcase
    end

    assign wreg = known && fetch_i.valid && (wd != '0);

    // ---------------------------------------------------------------------
    // ID/EX register
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            alu_op_q <= ALU_NOP;
            wreg_q   <= 1'b0;
        end else begin
            alu_op_q <= alu_op;                        // Already NOP when unknown
            wreg_q   <= wreg;
        end
    end

    always_ff @(posedge clk) begin
        opa_q <= opa;
        opb_q <= opb;
        wd_q  <= wd;
    end

    assign issue_o = '{alu_op: alu_op_q, opa: opa_q, opb: opb_q, wd: wd_q, wreg: wreg_q};

endmodule

//--- execute_stage.sv
module execute_stage (
    input  logic                 clk,
    input  logic                 reset_i,
    input  mips_pkg::issue_bus_t issue_i,
    output mips_pkg::wb_bus_t    ex_fwd_o,
    output mips_pkg::wb_bus_t    mem_fwd_o,
    output mips_pkg::wb_bus_t    wb_o
);
    import mips_pkg::*;

    logic [4:0] sh;                                    // Shift amount from opa
    word_t      alu_res;
    logic       mem_wreg_q;                            // EX/MEM
    reg_addr_t  mem_wd_q;
    word_t      mem_wdata_q;
    logic       wb_wreg_q;                             // MEM/WB
    reg_addr_t  wb_wd_q;
    word_t      wb_wdata_q;

    // ---------------------------------------------------------------------
    // ALU
    // ---------------------------------------------------------------------
    assign sh = issue_i.opa[4:0];

    always_comb begin
        alu_res = '0;
        case (issue_i.alu_op)
            ALU_OR:  alu_res = issue_i.opa | issue_i.opb;
            ALU_AND: alu_res = issue_i.opa & issue_i.opb;
            ALU_XOR: alu_res = issue_i.opa ^ issue_i.opb;
            ALU_NOR: alu_res = ~(issue_i.opa | issue_i.opb);
            ALU_ADD: alu_res = issue_i.opa + issue_i.opb;     // Mod 2^32
            ALU_SUB: alu_res = issue_i.opa - issue_i.opb;
            ALU_SLT: begin
                alu_res[0] = $signed(issue_i.opa) < $signed(issue_i.opb);
            end
            ALU_SLL: alu_res = issue_i.opb << sh;
            ALU_SRL: alu_res = issue_i.opb >> sh;             // Zero fill
            ALU_SRA: alu_res = $signed(issue_i.opb) >>> sh;   // Sign fill
            ALU_LUI: alu_res = issue_i.opb << 16;             // imm into [31:16]
            default: alu_res = '0;                            // ALU_NOP
        endcase
    end

    // Distance-1 forwarding tap, same cycle as the ALU
    assign ex_fwd_o = '{wreg: issue_i.wreg, wd: issue_i.wd, wdata: alu_res};

    // ---------------------------------------------------------------------
    // EX/MEM and MEM/WB registers
    // ---------------------------------------------------------------------
    // No loads or stores, so the memory stage only delays the result
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_wreg_q <= 1'b0;
            wb_wreg_q  <= 1'b0;
        end else begin
            mem_wreg_q <= ex_fwd_o.wreg;
            wb_wreg_q  <= mem_wreg_q;
        end
    end

    always_ff @(posedge clk) begin
        mem_wd_q    <= ex_fwd_o.wd;
        mem_wdata_q <= ex_fwd_o.wdata;
        wb_wd_q     <= mem_wd_q;
        wb_wdata_q  <= mem_wdata_q;
    end

    assign mem_fwd_o = '{wreg: mem_wreg_q, wd: mem_wd_q, wdata: mem_wdata_q};  // Distance 2
    assign wb_o      = '{wreg: wb_wreg_q, wd: wb_wd_q, wdata: wb_wdata_q};     // To regfile

endmodule

//--- openmips.sv
module openmips (
    input  logic                 clk,
    input  logic                 reset_i,
    output logic                 rom_ce_o,
    output mips_pkg::inst_addr_t rom_addr_o,
    input  mips_pkg::inst_t      rom_data_i,
    output mips_pkg::wb_bus_t    wb_o
);
    import mips_pkg::*;

    fetch_bus_t fetch_bus;                             // IF/ID
    issue_bus_t issue_bus;                             // ID/EX
    reg_addr_t  raddr1;
    reg_addr_t  raddr2;
    word_t      rdata1;
    word_t      rdata2;
    wb_bus_t    ex_fwd;                                // ALU output tap
    wb_bus_t    mem_fwd;                               // EX/MEM tap
    wb_bus_t    wb_bus;                                // MEM/WB, also the trace port

    // ---------------------------------------------------------------------
    // Pipeline stages
    // ---------------------------------------------------------------------
    fetch_stage u_fetch_stage (
        .clk        (clk),
        .reset_i    (reset_i),
        .rom_ce_o   (rom_ce_o),
        .rom_addr_o (rom_addr_o),
        .rom_data_i (rom_data_i),
        .fetch_o    (fetch_bus)
    );

    decode_stage u_decode_stage (
        .clk       (clk),
        .reset_i   (reset_i),
        .fetch_i   (fetch_bus),
        .raddr1_o  (raddr1),
        .raddr2_o  (raddr2),
        .rdata1_i  (rdata1),
        .rdata2_i  (rdata2),
        .ex_fwd_i  (ex_fwd),
        .mem_fwd_i (mem_fwd),
        .issue_o   (issue_bus)
    );

    regfile u_regfile (
        .clk      (clk),
        .reset_i  (reset_i),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .wb_i     (wb_bus)
    );

    execute_stage u_execute_stage (
        .clk       (clk),
        .reset_i   (reset_i),
        .issue_i   (issue_bus),
        .ex_fwd_o  (ex_fwd),
        .mem_fwd_o (mem_fwd),
        .wb_o      (wb_bus)
    );

    assign wb_o = wb_bus;                              // Retirement trace

endmodule

//--- openmips_checker.sv
`include "mips_defines.svh"

module openmips_checker (
    input logic                 clk,
    input logic                 reset_i,
    input logic                 rom_ce_i,
    input mips_pkg::inst_addr_t rom_addr_i,
    input mips_pkg::wb_bus_t    wb_i
);

    int unsigned err_count = 0;                        // Failed assertions so far

    // ---------------------------------------------------------------------
    // Fetch port
    // ---------------------------------------------------------------------
    // Enable is a register, so it drops one edge into reset
    a_ce_in_reset: assert property (@(posedge clk)
        reset_i && $past(reset_i) |-> !rom_ce_i)
        else begin
            $error("rom_ce_o high while reset_i held");
            err_count++;
        end

    a_addr_step: assert property (@(posedge clk) disable iff (reset_i)
        rom_ce_i && $past(rom_ce_i) |-> rom_addr_i == $past(rom_addr_i) + `MIPS_PC_STEP)
        else begin
            $error("rom_addr_o did not advance by one word");
            err_count++;
        end

    a_addr_align: assert property (@(posedge clk) disable iff (reset_i)
        rom_addr_i[1:0] == 2'b00)
        else begin
            $error("rom_addr_o not word aligned");
            err_count++;
        end

    // Writeback trace
    a_no_r0_write: assert property (@(posedge clk) disable iff (reset_i)
        wb_i.wreg |-> wb_i.wd != '0)
        else begin
            $error("writeback to register 0");
            err_count++;
        end

endmodule

bind openmips openmips_checker u_openmips_checker (
    .clk        (clk),
    .reset_i    (reset_i),
    .rom_ce_i   (rom_ce_o),
    .rom_addr_i (rom_addr_o),
    .wb_i       (wb_o)
);

//--- tb_openmips.sv
`include "mips_defines.svh"

module tb_openmips;
    import mips_pkg::*;

    localparam int          ROM_DEPTH   = 256;
    localparam int          WAIT_CYCLES = 40;           // Per-wait limit in clocks
    localparam logic [29:0] I_OPS = {`MIPS_OP_ORI, `MIPS_OP_ANDI, `MIPS_OP_XORI,
                                     `MIPS_OP_LUI, `MIPS_OP_ADDIU};
    localparam logic [59:0] R_FNS = {`MIPS_FN_AND, `MIPS_FN_OR, `MIPS_FN_XOR, `MIPS_FN_NOR,
                                     `MIPS_FN_ADDU, `MIPS_FN_SUBU, `MIPS_FN_SLT,
                                     `MIPS_FN_SLL, `MIPS_FN_SRL, `MIPS_FN_SRA};

    logic       clk;
    logic       reset_i;
    logic       rom_ce;
    inst_addr_t rom_addr;
    inst_t      rom_data;
    wb_bus_t    wb;
    inst_t      rom [ROM_DEPTH];                        // Program image
    word_t      ref_regs [`MIPS_REG_NUM];               // In-order register model
    wb_bus_t    exp_q [$];                              // Expected retirements
    int         emit_idx;                               // Next free ROM slot
    string      test_name;
    integer     seed = 32'heb99_195c;

    openmips dut0 (
        .clk        (clk),
        .reset_i    (reset_i),
        .rom_ce_o   (rom_ce),
        .rom_addr_o (rom_addr),
        .rom_data_i (rom_data),
        .wb_o       (wb)
    );

    // Word-indexed ROM, reads past the image return NOP
    assign rom_data = ((rom_addr >> 2) < ROM_DEPTH) ? rom[rom_addr >> 2] : '0;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ---------------------------------------------------------------------
    // Reporting and encoding
    // ---------------------------------------------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s %s expected %0h actual %0h",
                               test_name, what, exp, act));
        end
    endtask

    // Bound port assertions
    always @(negedge clk) begin
        if (dut0.u_openmips_checker.err_count != 0) begin
            fail_run("A bound assertion in openmips_checker failed");
        end
    end

    function automatic inst_t enc_r(logic [5:0] fn, reg_addr_t rd, reg_addr_t rs,
                                    reg_addr_t rt, logic [4:0] sa);
        return {`MIPS_OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic inst_t enc_i(logic [5:0] op, reg_addr_t rt, reg_addr_t rs,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // MIPS32 meaning of each kept R-type funct
    function automatic word_t model_r(logic [5:0] fn, word_t a, word_t b, logic [4:0] sa);
        word_t res;
        case (fn)
            `MIPS_FN_AND:  res = a & b;
            `MIPS_FN_OR:   res = a | b;
            `MIPS_FN_XOR:  res = a ^ b;
            `MIPS_FN_NOR:  res = ~(a | b);
            `MIPS_FN_ADDU: res = a + b;                 // Wraps
            `MIPS_FN_SUBU: res = a - b;
            `MIPS_FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `MIPS_FN_SLL:  res = b << sa;
            `MIPS_FN_SRL:  res = b >> sa;
            `MIPS_FN_SRA:  res = $signed(b) >>> sa;
            default:       res = 'x;
        endcase
        return res;
    endfunction

    function automatic word_t model_i(logic [5:0] op, word_t a, logic [15:0] imm);
        word_t res;
        case (op)
            `MIPS_OP_ORI:   res = a | {16'h0, imm};     // Zero-extended
            `MIPS_OP_ANDI:  res = a & {16'h0, imm};
            `MIPS_OP_XORI:  res = a ^ {16'h0, imm};
            `MIPS_OP_LUI:   res = {imm, 16'h0};
            `MIPS_OP_ADDIU: res = a + {{16{imm[15]}}, imm};
            default:        res = 'x;
        endcase
        return res;
    endfunction

    // ---------------------------------------------------------------------
    // Program building and response checking
    // ---------------------------------------------------------------------
    task automatic start_program(input string name);
        test_name = name;
        emit_idx  = 0;
        exp_q.delete();
        for (int i = 0; i < ROM_DEPTH; i++) begin
            rom[i] = '0;                                // NOP fill
        end
        for (int i = 0; i < `MIPS_REG_NUM; i++) begin
            ref_regs[i] = '0;
        end
    endtask

    task automatic emit_raw(input inst_t inst);
        rom[emit_idx] = inst;
        emit_idx++;
    endtask

    task automatic note_write(input reg_addr_t wd, input word_t val);
        if (wd != '0) begin                             // r0 retires silently
            ref_regs[wd] = val;
            exp_q.push_back('{wreg: 1'b1, wd: wd, wdata: val});
        end
    endtask

    task automatic emit_r(input logic [5:0] fn, input reg_addr_t rd, input reg_addr_t rs,
                          input reg_addr_t rt, input logic [4:0] sa);
        emit_raw(enc_r(fn, rd, rs, rt, sa));
        note_write(rd, model_r(fn, ref_regs[rs], ref_regs[rt], sa));
    endtask

    task automatic emit_i(input logic [5:0] op, input reg_addr_t rt, input reg_addr_t rs,
                          input logic [15:0] imm);
        emit_raw(enc_i(op, rt, rs, imm));
        note_write(rt, model_i(op, ref_regs[rs], imm));
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset_i = 1'b1;
        repeat (8) @(negedge clk);
        reset_i = 1'b0;
    endtask

    task automatic wait_write(input string what, output int cycles);
        logic found;
        cycles = 0;
        found  = 1'b0;
        while (!found && cycles < WAIT_CYCLES) begin
            @(negedge clk);
            cycles++;
            found = (wb.wreg === 1'b1);
        end
        if (!found) begin
            fail_run($sformatf("Timeout in %s waiting for writeback %s", test_name, what));
        end
    endtask

    task automatic check_writes();
        wb_bus_t exp;
        int      cycles;
        int      n;
        n = 0;
        while (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            wait_write($sformatf("#%0d", n), cycles);
            check_value($sformatf("write %0d index", n), exp.wd, wb.wd);
            check_value($sformatf("write %0d data", n), exp.wdata, wb.wdata);
            n++;
        end
        repeat (8) begin                                // Tail must stay silent
            @(negedge clk);
            check_value("idle wreg", 1'b0, wb.wreg);
        end
    endtask

    // ---------------------------------------------------------------------
    // Directed tests
    // ---------------------------------------------------------------------
    task automatic test_fetch();
        wb_bus_t exp;
        int      cycles;
        logic    seen;
        start_program("fetch");
        emit_i(`MIPS_OP_ORI, 5'd1, 5'd0, 16'h1234);
        emit_i(`MIPS_OP_ADDIU, 5'd2, 5'd1, 16'h0001);
        apply_reset();
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < WAIT_CYCLES) begin
            @(negedge clk);
            cycles++;
            seen = (rom_ce === 1'b1);
        end
        if (!seen) begin
            fail_run("Timeout in fetch waiting for rom_ce_o to rise after reset");
        end
        check_value("first address", `MIPS_RESET_PC, rom_addr);
        wait_write("#0", cycles);
        check_value("writeback latency", 4, cycles);
        check_value("address after 4 steps", `MIPS_RESET_PC + 4 * `MIPS_PC_STEP, rom_addr);
        exp = exp_q.pop_front();
        check_value("first write index", exp.wd, wb.wd);
        check_value("first write data", exp.wdata, wb.wdata);
        check_writes();
    endtask

    task automatic test_immediate();
        start_program("immediate");
        emit_i(`MIPS_OP_ORI, 5'd1, 5'd0, 16'h8f0f);
        emit_i(`MIPS_OP_ANDI, 5'd2, 5'd1, 16'hf0ff);
        emit_i(`MIPS_OP_XORI, 5'd3, 5'd1, 16'hffff);
        emit_i(`MIPS_OP_LUI, 5'd4, 5'd0, 16'h8765);
        emit_i(`MIPS_OP_ADDIU, 5'd5, 5'd4, 16'hfffe);    // Negative immediate
        emit_i(`MIPS_OP_ADDIU, 5'd6, 5'd0, 16'h8000);    // Sign extension
        emit_i(`MIPS_OP_ORI, 5'd7, 5'd4, 16'h4321);
        apply_reset();
        check_writes();
    endtask

    task automatic test_register();
        logic [15:0] hi;
        logic [15:0] lo;
        logic [4:0]  sa1;
        logic [4:0]  sa2;
        hi  = $random(seed);
        lo  = $random(seed);
        sa1 = $random(seed);
        sa2 = $random(seed);
        start_program("register");
        emit_i(`MIPS_OP_ADDIU, 5'd1, 5'd0, 16'hffff);    // All ones
        emit_i(`MIPS_OP_ADDIU, 5'd2, 5'd0, 16'h0002);
        emit_i(`MIPS_OP_LUI, 5'd3, 5'd0, hi | 16'h8000);  // Negative random word
        emit_i(`MIPS_OP_ORI, 5'd3, 5'd3, lo);
        emit_i(`MIPS_OP_ADDIU, 5'd4, 5'd0, 16'hfffb);    // -5
        emit_r(`MIPS_FN_AND, 5'd5, 5'd3, 5'd1, 5'd0);
        emit_r(`MIPS_FN_OR, 5'd6, 5'd3, 5'd2, 5'd0);
        emit_r(`MIPS_FN_XOR, 5'd7, 5'd3, 5'd4, 5'd0);
        emit_r(`MIPS_FN_NOR, 5'd8, 5'd3, 5'd2, 5'd0);
        emit_r(`MIPS_FN_ADDU, 5'd9, 5'd1, 5'd2, 5'd0);   // Wraps to 1
        emit_r(`MIPS_FN_SUBU, 5'd10, 5'd2, 5'd1, 5'd0);
        emit_r(`MIPS_FN_SLT, 5'd11, 5'd4, 5'd2, 5'd0);
        emit_r(`MIPS_FN_SLT, 5'd12, 5'd2, 5'd4, 5'd0);
        emit_r(`MIPS_FN_SLT, 5'd13, 5'd4, 5'd1, 5'd0);   // Both negative
        emit_r(`MIPS_FN_SLL, 5'd14, 5'd0, 5'd3, sa1);
        emit_r(`MIPS_FN_SRL, 5'd15, 5'd0, 5'd4, sa1);
        emit_r(`MIPS_FN_SRA, 5'd16, 5'd0, 5'd4, sa2);
        emit_r(`MIPS_FN_SRA, 5'd17, 5'd0, 5'd3, sa2);
        apply_reset();
        check_writes();
    endtask

    task automatic test_forwarding();
        start_program("forwarding");
        emit_i(`MIPS_OP_ORI, 5'd1, 5'd0, 16'h0011);
        emit_i(`MIPS_OP_ADDIU, 5'd1, 5'd1, 16'h0100);    // Distance 1
        emit_r(`MIPS_FN_ADDU, 5'd2, 5'd1, 5'd1, 5'd0);
        emit_r(`MIPS_FN_XOR, 5'd3, 5'd2, 5'd1, 5'd0);    // Distances 1 and 2
        emit_i(`MIPS_OP_ORI, 5'd4, 5'd0, 16'h7000);
        emit_r(`MIPS_FN_SUBU, 5'd5, 5'd3, 5'd2, 5'd0);   // Distances 2 and 3
        emit_r(`MIPS_FN_ADDU, 5'd6, 5'd1, 5'd5, 5'd0);
        emit_r(`MIPS_FN_SLL, 5'd7, 5'd0, 5'd5, 5'd3);
        emit_i(`MIPS_OP_ORI, 5'd8, 5'd0, 16'h0001);
        emit_i(`MIPS_OP_ORI, 5'd8, 5'd0, 16'h0002);      // Youngest must win
        emit_r(`MIPS_FN_ADDU, 5'd9, 5'd8, 5'd7, 5'd0);
        emit_r(`MIPS_FN_OR, 5'd1, 5'd6, 5'd9, 5'd0);
        emit_r(`MIPS_FN_ADDU, 5'd2, 5'd1, 5'd4, 5'd0);
        apply_reset();
        check_writes();
    endtask

    task automatic test_suppressed();
        start_program("suppressed");
        emit_i(`MIPS_OP_ORI, 5'd1, 5'd0, 16'h00aa);
        emit_i(`MIPS_OP_ORI, 5'd0, 5'd1, 16'h5555);      // r0 target
        emit_r(`MIPS_FN_ADDU, 5'd0, 5'd1, 5'd1, 5'd0);
        emit_raw(enc_i(6'b100011, 5'd2, 5'd1, 16'h0004)); // LW, not kept
        emit_raw(enc_r(6'b011000, 5'd3, 5'd1, 5'd1, 5'd0)); // MULT funct
        emit_r(`MIPS_FN_ADDU, 5'd4, 5'd0, 5'd1, 5'd0);   // r0 reads zero
        emit_r(`MIPS_FN_OR, 5'd5, 5'd0, 5'd0, 5'd0);
        emit_r(`MIPS_FN_ADDU, 5'd6, 5'd2, 5'd3, 5'd0);   // Both left at zero
        emit_raw(enc_i(6'b101011, 5'd7, 5'd1, 16'h0008)); // SW at the tail
        apply_reset();
        check_writes();
    endtask

    task automatic test_random();
        int          k;
        reg_addr_t   d;
        reg_addr_t   s;
        reg_addr_t   t;
        logic [15:0] imm;
        logic [4:0]  sa;
        start_program("random");
        for (int i = 0; i < 40; i++) begin
            k   = {$random(seed)} % 15;
            d   = 1 + ({$random(seed)} % 7);
            s   = 1 + ({$random(seed)} % 7);
            t   = 1 + ({$random(seed)} % 7);
            imm = $random(seed);
            sa  = $random(seed);
            if (k < 5) begin
                emit_i(I_OPS[k*6 +: 6], d, s, imm);
            end else begin
                emit_r(R_FNS[(k-5)*6 +: 6], d, s, t, sa);
            end
        end
        apply_reset();
        check_writes();
    endtask

    initial begin
        reset_i = 1'b1;
        start_program("init");                          // Defined ROM from time 0
        test_fetch();
        test_immediate();
        test_register();
        test_forwarding();
        test_suppressed();
        test_random();
        if (dut0.u_openmips_checker.err_count != 0) begin
            fail_run("A bound assertion in openmips_checker failed");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- list.f
+incdir+.
mips_pkg.sv
fetch_stage.sv
regfile.sv
decode_stage.sv
execute_stage.sv
openmips.sv
openmips_checker.sv
tb_openmips.sv

//--- Bender.yml
package:
  name: openmips

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mips_pkg.sv
      - fetch_stage.sv
      - regfile.sv
      - decode_stage.sv
      - execute_stage.sv
      - openmips.sv
  - target: test
    include_dirs:
      - .
    files:
      - openmips_checker.sv
      - tb_openmips.sv
